// File: src/alu_fu_params.svh
`ifndef ALU_FU_PARAMS_SVH
`define ALU_FU_PARAMS_SVH

// data and address width
`define XLEN 32

// reorder buffer tag, 32 entries
`define TAG_BITS 5

// fall-through step, one instruction
`define INST_BYTES 4

// shift amount field of operand b
`define SHAMT_BITS 5

// poison words, easy to spot in a waveform
`define BAD_OPERAND 32'hdeadface
`define BAD_RESULT 32'hfacebeec

`endif

// File: src/alu_fu_pkg.sv
package alu_fu_pkg;

    // integer ALU operations, the encoding is internal to the unit
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_slt  = 4'h5, // signed
        alu_sltu = 4'h6,
        alu_sll  = 4'h7,
        alu_srl  = 4'h8,
        alu_sra  = 4'h9  // shifts in the sign
    } alu_func_e;

    // operand a source
    typedef enum logic [1:0] {
        opa_rs1  = 2'h0,
        opa_npc  = 2'h1, // predicted next pc
        opa_pc   = 2'h2, // auipc, jal link math
        opa_zero = 2'h3  // lui
    } opa_sel_e;

    // operand b source
    // codes 5 to 7 are unused and give the poison operand
    typedef enum logic [2:0] {
        opb_rs2   = 3'h0,
        opb_i_imm = 3'h1,
        opb_b_imm = 3'h2,
        opb_u_imm = 3'h3,
        opb_j_imm = 3'h4
    } opb_sel_e;

    // conditional branch type, same codes as funct3 of the B format
    // 3'b010 and 3'b011 are not branches
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } branch_cond_e;

endpackage

// File: src/issue_if.sv
`timescale 1ns/1ps
`include "alu_fu_params.svh"

// one issued instruction, driven by the top level only
interface issue_if;

    logic                      valid;
    logic [`XLEN-1:0]          pc;
    logic [`XLEN-1:0]          npc;       // predicted next pc
    logic [31:0]               inst;
    logic [`XLEN-1:0]          rs1_value;
    logic [`XLEN-1:0]          rs2_value;
    alu_fu_pkg::opa_sel_e      opa_sel;
    alu_fu_pkg::opb_sel_e      opb_sel;
    alu_fu_pkg::alu_func_e     alu_func;
    logic                      cond_branch;
    logic                      uncond_branch;
    logic [`TAG_BITS-1:0]      tag;
    logic                      halt;

    // operand muxes
    modport operands (
        input pc, npc, inst, rs1_value, rs2_value, opa_sel, opb_sel
    );

    // branch condition check
    modport compare (
        input inst, rs1_value, rs2_value
    );

    // next pc and output registers
    modport resolve (
        input valid, pc, npc, cond_branch, uncond_branch, tag, halt
    );

endinterface

// File: src/operand_select.sv
`timescale 1ns/1ps
`include "alu_fu_params.svh"

module operand_select (
    issue_if.operands        ops,
    output logic [`XLEN-1:0] opa,
    output logic [`XLEN-1:0] opb
);

    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] u_imm;
    logic [`XLEN-1:0] j_imm;

    // I type, inst[31:20]
    assign i_imm = {{(`XLEN-12){ops.inst[31]}}, ops.inst[31:20]};

    // B type, halfword aligned branch offset
    assign b_imm = {{(`XLEN-13){ops.inst[31]}},
                    ops.inst[31],
                    ops.inst[7],
                    ops.inst[30:25],
                    ops.inst[11:8],
                    1'b0};

    // U type, upper 20 bits
    assign u_imm = {ops.inst[31:12], 12'b0};

    // J type, jal offset
    assign j_imm = {{(`XLEN-21){ops.inst[31]}},
                    ops.inst[31],
                    ops.inst[19:12],
                    ops.inst[20],
                    ops.inst[30:21],
                    1'b0};

    // operand a
    always_comb begin
        case (ops.opa_sel)
            alu_fu_pkg::opa_rs1:  opa = ops.rs1_value;
            alu_fu_pkg::opa_npc:  opa = ops.npc;
            alu_fu_pkg::opa_pc:   opa = ops.pc;
            alu_fu_pkg::opa_zero: opa = '0;
            default:              opa = `BAD_OPERAND;
        endcase
    end

    // operand b
    always_comb begin
        case (ops.opb_sel)
            alu_fu_pkg::opb_rs2:   opb = ops.rs2_value;
            alu_fu_pkg::opb_i_imm: opb = i_imm;
            alu_fu_pkg::opb_b_imm: opb = b_imm;
            alu_fu_pkg::opb_u_imm: opb = u_imm;
            alu_fu_pkg::opb_j_imm: opb = j_imm;
            default:               opb = `BAD_OPERAND; // unused select codes
        endcase
    end

endmodule

// File: src/int_alu.sv
`timescale 1ns/1ps
`include "alu_fu_params.svh"

module int_alu (
    input  logic [`XLEN-1:0]    opa,
    input  logic [`XLEN-1:0]    opb,
    input  alu_fu_pkg::alu_func_e func,
    output logic [`XLEN-1:0]    alu_result
);

    logic signed [`XLEN-1:0] signed_opa;
    logic signed [`XLEN-1:0] signed_opb;
    logic [`SHAMT_BITS-1:0]  shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    assign signed_opa  = opa;
    assign signed_opb  = opb;
    assign shamt       = opb[`SHAMT_BITS-1:0]; // upper bits of opb ignored
    assign lt_signed   = signed_opa < signed_opb;
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (func)
            alu_fu_pkg::alu_add:  alu_result = opa + opb;
            alu_fu_pkg::alu_sub:  alu_result = opa - opb;
            alu_fu_pkg::alu_and:  alu_result = opa & opb;
            alu_fu_pkg::alu_or:   alu_result = opa | opb;
            alu_fu_pkg::alu_xor:  alu_result = opa ^ opb;
            alu_fu_pkg::alu_slt:  alu_result = {{(`XLEN-1){1'b0}}, lt_signed};
            alu_fu_pkg::alu_sltu: alu_result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            alu_fu_pkg::alu_sll:  alu_result = opa << shamt;
            alu_fu_pkg::alu_srl:  alu_result = opa >> shamt;
            alu_fu_pkg::alu_sra:  alu_result = signed_opa >>> shamt;
            default:              alu_result = `BAD_RESULT;
        endcase
    end

endmodule

// File: src/branch_compare.sv
`timescale 1ns/1ps
`include "alu_fu_params.svh"

module branch_compare (
    issue_if.compare cmp,
    output logic     cond_true
);

    alu_fu_pkg::branch_cond_e cond;
    logic signed [`XLEN-1:0]  signed_rs1;
    logic signed [`XLEN-1:0]  signed_rs2;

    assign cond       = alu_fu_pkg::branch_cond_e'(cmp.inst[14:12]); // funct3
    assign signed_rs1 = cmp.rs1_value;
    assign signed_rs2 = cmp.rs2_value;

    always_comb begin
        case (cond)
            alu_fu_pkg::br_eq:  cond_true = cmp.rs1_value == cmp.rs2_value;
            alu_fu_pkg::br_ne:  cond_true = cmp.rs1_value != cmp.rs2_value;
            alu_fu_pkg::br_lt:  cond_true = signed_rs1 < signed_rs2;
            alu_fu_pkg::br_ge:  cond_true = signed_rs1 >= signed_rs2;
            alu_fu_pkg::br_ltu: cond_true = cmp.rs1_value < cmp.rs2_value;
            alu_fu_pkg::br_geu: cond_true = cmp.rs1_value >= cmp.rs2_value;
            default:            cond_true = 1'b0; // funct3 010, 011
        endcase
    end

endmodule

// File: src/branch_resolve.sv
`timescale 1ns/1ps
`include "alu_fu_params.svh"

module branch_resolve (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 clear,
    issue_if.resolve             res,
    input  logic [`XLEN-1:0]     alu_result,
    input  logic                 cond_true,
    output logic                 result_valid,
    output logic [`XLEN-1:0]     result,
    output logic [`XLEN-1:0]     next_pc,
    output logic                 redirect,
    output logic [`TAG_BITS-1:0] result_tag,
    output logic                 result_halt
);

    logic             taken;
    logic [`XLEN-1:0] fall_pc;
    logic [`XLEN-1:0] correct_pc;
    logic             mispredict;

    // jumps always go, branches only on a true condition
    assign taken = res.uncond_branch | (res.cond_branch & cond_true);

    assign fall_pc    = res.pc + `XLEN'(`INST_BYTES);
    assign correct_pc = taken ? alu_result : fall_pc; // target comes out of the ALU

    // covers every prediction case, a wrong target included
    assign mispredict = res.valid && (res.npc != correct_pc);

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            result_valid <= 1'b0; // also drops the instruction issued with clear
            result       <= '0;
            next_pc      <= '0;
            redirect     <= 1'b0;
            result_tag   <= '0;
            result_halt  <= 1'b0;
        end else begin
            result_valid <= res.valid;
            result       <= alu_result;
            next_pc      <= correct_pc;
            redirect     <= mispredict;
            result_tag   <= res.tag;
            result_halt  <= res.halt;
        end
    end

endmodule

// File: src/alu_fu.sv
`timescale 1ns/1ps
`include "alu_fu_params.svh"

module alu_fu (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      clear,
    input  logic                      issue_valid,
    input  logic [`XLEN-1:0]          pc,
    input  logic [`XLEN-1:0]          npc,           // predicted next pc
    input  logic [31:0]               inst,
    input  logic [`XLEN-1:0]          rs1_value,
    input  logic [`XLEN-1:0]          rs2_value,
    input  alu_fu_pkg::opa_sel_e      opa_sel,
    input  alu_fu_pkg::opb_sel_e      opb_sel,
    input  alu_fu_pkg::alu_func_e     alu_func,
    input  logic                      cond_branch,
    input  logic                      uncond_branch,
    input  logic [`TAG_BITS-1:0]      tag,
    input  logic                      halt,
    output logic                      result_valid,
    output logic [`XLEN-1:0]          result,
    output logic [`XLEN-1:0]          next_pc,
    output logic                      redirect,
    output logic [`TAG_BITS-1:0]      result_tag,
    output logic                      result_halt
);

    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic [`XLEN-1:0] alu_result;
    logic             cond_true;

    issue_if iss ();

    assign iss.valid         = issue_valid;
    assign iss.pc            = pc;
    assign iss.npc           = npc;
    assign iss.inst          = inst;
    assign iss.rs1_value     = rs1_value;
    assign iss.rs2_value     = rs2_value;
    assign iss.opa_sel       = opa_sel;
    assign iss.opb_sel       = opb_sel;
    assign iss.alu_func      = alu_func;
    assign iss.cond_branch   = cond_branch;
    assign iss.uncond_branch = uncond_branch;
    assign iss.tag           = tag;
    assign iss.halt          = halt;

    operand_select operand_select0 (
        .ops (iss.operands),
        .opa (opa),
        .opb (opb)
    );

    int_alu int_alu0 (
        .opa        (opa),
        .opb        (opb),
        .func       (iss.alu_func),
        .alu_result (alu_result)
    );

    // runs beside the ALU on the raw register values
    branch_compare branch_compare0 (
        .cmp       (iss.compare),
        .cond_true (cond_true)
    );

    branch_resolve branch_resolve0 (
        .clock        (clock),
        .reset        (reset),
        .clear        (clear),
        .res          (iss.resolve),
        .alu_result   (alu_result),
        .cond_true    (cond_true),
        .result_valid (result_valid),
        .result       (result),
        .next_pc      (next_pc),
        .redirect     (redirect),
        .result_tag   (result_tag),
        .result_halt  (result_halt)
    );

endmodule

// File: testbench/alu_fu_properties.sv
`timescale 1ns/1ps

module alu_fu_properties (
    input logic clock,
    input logic reset,
    input logic clear,
    input logic issue_valid,
    input logic result_valid,
    input logic redirect,
    input logic result_halt
);

    // a flushing edge leaves nothing behind
    property flush_clears_outputs;
        @(posedge clock) (reset || clear) |=> (!result_valid && !redirect && !result_halt);
    endproperty

    // fixed one cycle latency, no stalls
    property valid_follows_issue;
        @(posedge clock) (!reset && !clear) |=> (result_valid == $past(issue_valid));
    endproperty

    property redirect_needs_valid;
        @(posedge clock) disable iff (reset) redirect |-> result_valid;
    endproperty

    flush_check: assert property (flush_clears_outputs)
        else $error("outputs not cleared after reset or clear");

    latency_check: assert property (valid_follows_issue)
        else $error("result_valid does not follow issue_valid by one cycle");

    redirect_check: assert property (redirect_needs_valid)
        else $error("redirect raised without result_valid");

endmodule

bind alu_fu alu_fu_properties props0 (
    .clock        (clock),
    .reset        (reset),
    .clear        (clear),
    .issue_valid  (issue_valid),
    .result_valid (result_valid),
    .redirect     (redirect),
    .result_halt  (result_halt)
);

// File: testbench/tb_alu_fu.sv
`timescale 1ns/1ps
`include "alu_fu_params.svh"

module tb_alu_fu;

    localparam int STIM_CYCLES  = 2000;
    localparam int SWEEP_CYCLES = 12 * 4 * 6; // func x opa x opb codes, illegal ones included
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = 3000;       // reset + stimulus + margin

    typedef struct packed {
        logic                 flush;    // reset or clear at the sampling edge
        logic                 valid;
        logic [`XLEN-1:0]     result;
        logic [`XLEN-1:0]     next_pc;
        logic                 redirect;
        logic [`TAG_BITS-1:0] tag;
        logic                 halt;
    } expect_t;

    logic                  clock;
    logic                  reset;
    logic                  clear;
    logic                  issue_valid;
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      npc;
    logic [31:0]           inst;
    logic [`XLEN-1:0]      rs1_value;
    logic [`XLEN-1:0]      rs2_value;
    alu_fu_pkg::opa_sel_e  opa_sel;
    alu_fu_pkg::opb_sel_e  opb_sel;
    alu_fu_pkg::alu_func_e alu_func;
    logic                  cond_branch;
    logic                  uncond_branch;
    logic [`TAG_BITS-1:0]  tag;
    logic                  halt;
    logic                  result_valid;
    logic [`XLEN-1:0]      result;
    logic [`XLEN-1:0]      next_pc;
    logic                  redirect;
    logic [`TAG_BITS-1:0]  result_tag;
    logic                  result_halt;

    logic [31:0] rng_state;
    expect_t     pending_q[$]; // never more than one entry deep
    int          cycle_count = 0;

    alu_fu dut0 (
        .clock         (clock),
        .reset         (reset),
        .clear         (clear),
        .issue_valid   (issue_valid),
        .pc            (pc),
        .npc           (npc),
        .inst          (inst),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .opa_sel       (opa_sel),
        .opb_sel       (opb_sel),
        .alu_func      (alu_func),
        .cond_branch   (cond_branch),
        .uncond_branch (uncond_branch),
        .tag           (tag),
        .halt          (halt),
        .result_valid  (result_valid),
        .result        (result),
        .next_pc       (next_pc),
        .redirect      (redirect),
        .result_tag    (result_tag),
        .result_halt   (result_halt)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // shift the field to the top, then back down arithmetically
    function automatic logic [31:0] sign_extend(input logic [31:0] value, input int width);
        logic signed [31:0] shifted;
        shifted = value << (32 - width);
        return shifted >>> (32 - width);
    endfunction

    function automatic expect_t reference(
        input logic [31:0] ref_pc,
        input logic [31:0] ref_npc,
        input logic [31:0] ref_inst,
        input logic [31:0] ref_rs1,
        input logic [31:0] ref_rs2,
        input logic [1:0]  opa_code,
        input logic [2:0]  opb_code,
        input logic [3:0]  func_code,
        input logic        is_cond,
        input logic        is_jump
    );
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic        cond;
        logic        taken;
        e = '0;
        case (opa_code)
            alu_fu_pkg::opa_rs1: a = ref_rs1;
            alu_fu_pkg::opa_npc: a = ref_npc;
            alu_fu_pkg::opa_pc:  a = ref_pc;
            default:             a = 32'd0;
        endcase
        case (opb_code)
            alu_fu_pkg::opb_rs2:   b = ref_rs2;
            alu_fu_pkg::opb_i_imm: b = sign_extend({20'b0, ref_inst[31:20]}, 12);
            alu_fu_pkg::opb_b_imm: b = sign_extend({19'b0, ref_inst[31], ref_inst[7],
                                                    ref_inst[30:25], ref_inst[11:8], 1'b0}, 13);
            alu_fu_pkg::opb_u_imm: b = ref_inst & 32'hfffff000;
            alu_fu_pkg::opb_j_imm: b = sign_extend({11'b0, ref_inst[31], ref_inst[19:12],
                                                    ref_inst[20], ref_inst[30:21], 1'b0}, 21);
            default:               b = `BAD_OPERAND;
        endcase
        case (func_code)
            alu_fu_pkg::alu_add:  e.result = a + b;
            alu_fu_pkg::alu_sub:  e.result = a - b;
            alu_fu_pkg::alu_and:  e.result = a & b;
            alu_fu_pkg::alu_or:   e.result = a | b;
            alu_fu_pkg::alu_xor:  e.result = a ^ b;
            alu_fu_pkg::alu_slt:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_fu_pkg::alu_sltu: e.result = (a < b) ? 32'd1 : 32'd0;
            alu_fu_pkg::alu_sll:  e.result = a << b[4:0];
            alu_fu_pkg::alu_srl:  e.result = a >> b[4:0];
            alu_fu_pkg::alu_sra:  e.result = $signed(a) >>> b[4:0];
            default:              e.result = `BAD_RESULT;
        endcase
        case (ref_inst[14:12]) // funct3
            3'b000:  cond = (ref_rs1 == ref_rs2);
            3'b001:  cond = (ref_rs1 != ref_rs2);
            3'b100:  cond = ($signed(ref_rs1) < $signed(ref_rs2));
            3'b101:  cond = ($signed(ref_rs1) >= $signed(ref_rs2));
            3'b110:  cond = (ref_rs1 < ref_rs2);
            3'b111:  cond = (ref_rs1 >= ref_rs2);
            default: cond = 1'b0;
        endcase
        taken      = is_jump || (is_cond && cond);
        e.next_pc  = taken ? e.result : ref_pc + `XLEN'(`INST_BYTES);
        e.redirect = (ref_npc != e.next_pc);
        return e;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, want);
            $display("Testbench failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_value("result_valid", 32'(result_valid), 32'(e.valid));
        if (e.flush) begin
            check_value("result after flush", result, 32'd0);
            check_value("next_pc after flush", next_pc, 32'd0);
            check_value("redirect after flush", 32'(redirect), 32'd0);
            check_value("result_tag after flush", 32'(result_tag), 32'd0);
            check_value("result_halt after flush", 32'(result_halt), 32'd0);
        end else if (e.valid) begin
            check_value("result", result, e.result);
            check_value("next_pc", next_pc, e.next_pc);
            check_value("redirect", 32'(redirect), 32'(e.redirect));
            check_value("result_tag", 32'(result_tag), 32'(e.tag));
            check_value("result_halt", 32'(result_halt), 32'(e.halt));
        end else begin
            check_value("redirect while idle", 32'(redirect), 32'd0);
        end
    endtask

    // index below SWEEP_CYCLES walks all func/opa/opb codes, the rest is random
    task automatic drive_cycle(input int index, input logic in_reset);
        logic [31:0] r;
        logic        sweep;
        logic [1:0]  a_code;
        logic [2:0]  b_code;
        logic [3:0]  f_code;
        logic        is_cond;
        logic        is_jump;
        logic [31:0] v_pc;
        logic [31:0] v_npc;
        logic [31:0] v_inst;
        logic [31:0] v_rs1;
        logic [31:0] v_rs2;
        expect_t     e;
        r       = next_random();
        sweep   = (index >= 0) && (index < SWEEP_CYCLES);
        v_pc    = next_random() & ~32'h3;
        v_inst  = next_random();
        v_rs1   = next_random();
        v_rs2   = (r[1:0] == 2'd0) ? v_rs1 : next_random(); // equal values for eq/ge cases
        is_cond = 1'b0;
        is_jump = 1'b0;
        a_code  = alu_fu_pkg::opa_pc; // branch target math
        b_code  = alu_fu_pkg::opb_b_imm;
        f_code  = alu_fu_pkg::alu_add;
        if (sweep) begin
            f_code = 4'(index % 12);
            a_code = 2'((index / 12) % 4);
            b_code = 3'(index / 48);
        end else begin
            case (r[4:2])
                3'd4, 3'd5: is_cond = 1'b1;
                3'd6: begin
                    is_jump = 1'b1; // jal
                    b_code  = alu_fu_pkg::opb_j_imm;
                end
                3'd7: begin
                    is_jump = 1'b1; // jalr
                    a_code  = alu_fu_pkg::opa_rs1;
                    b_code  = alu_fu_pkg::opb_i_imm;
                end
                default: begin
                    a_code = r[6:5];
                    b_code = 3'(r[10:7] % 6);
                    f_code = 4'(r[15:11] % 12);
                end
            endcase
        end
        // first pass only to learn the correct target for a right prediction
        e = reference(v_pc, v_pc + 32'd4, v_inst, v_rs1, v_rs2, a_code, b_code, f_code,
                      is_cond, is_jump);
        case (r[17:16])
            2'd0, 2'd1: v_npc = v_pc + 32'd4;
            2'd2:       v_npc = next_random();
            default:    v_npc = e.next_pc;
        endcase
        e = reference(v_pc, v_npc, v_inst, v_rs1, v_rs2, a_code, b_code, f_code,
                      is_cond, is_jump);
        reset         = in_reset;
        clear         = !sweep && (r[25:21] == 5'd0);
        issue_valid   = sweep || (r[20:18] != 3'd0);
        pc            = v_pc;
        npc           = v_npc;
        inst          = v_inst;
        rs1_value     = v_rs1;
        rs2_value     = v_rs2;
        opa_sel       = alu_fu_pkg::opa_sel_e'(a_code);
        opb_sel       = alu_fu_pkg::opb_sel_e'(b_code);
        alu_func      = alu_fu_pkg::alu_func_e'(f_code);
        cond_branch   = is_cond;
        uncond_branch = is_jump;
        tag           = r[30:26];
        halt          = r[31];
        e.flush       = in_reset || clear;
        e.valid       = issue_valid && !e.flush;
        e.redirect    = e.redirect && e.valid;
        e.tag         = r[30:26];
        e.halt        = r[31];
        pending_q.push_back(e);
    endtask

    initial begin
        rng_state     = 32'd83;
        clock         = 1'b0;
        reset         = 1'b1;
        clear         = 1'b0;
        issue_valid   = 1'b0;
        pc            = '0;
        npc           = '0;
        inst          = '0;
        rs1_value     = '0;
        rs2_value     = '0;
        opa_sel       = alu_fu_pkg::opa_rs1;
        opb_sel       = alu_fu_pkg::opb_rs2;
        alu_func      = alu_fu_pkg::alu_add;
        cond_branch   = 1'b0;
        uncond_branch = 1'b0;
        tag           = '0;
        halt          = 1'b0;
        drive_cycle(-1, 1'b1);
        repeat (RESET_CYCLES - 1) begin
            @(negedge clock);
            drive_cycle(-1, 1'b1);
        end
        for (int i = 0; i < STIM_CYCLES; i++) begin
            @(negedge clock);
            drive_cycle(i, 1'b0);
        end
        repeat (2) @(posedge clock); // last result checked by now
        $display("Testbench passed");
        $finish;
    end

    // pop at the sampling edge, compare once the registers have settled
    initial begin : compare_results
        expect_t exp_now;
        forever begin
            @(posedge clock);
            if (pending_q.size() > 0) begin
                exp_now = pending_q.pop_front();
                @(negedge clock);
                check_outputs(exp_now);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

endmodule

// File: alu_fu.f
+incdir+src
src/alu_fu_pkg.sv
src/issue_if.sv
src/operand_select.sv
src/int_alu.sv
src/branch_compare.sv
src/branch_resolve.sv
src/alu_fu.sv
testbench/alu_fu_properties.sv
testbench/tb_alu_fu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the alu_fu testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_alu_fu -f alu_fu.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_alu_fu 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^Testbench passed$"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
